// ==== hw/trigger_csr_regs.sv ====
// tselect and per-trigger config behind the csr path; illegal writes are dropped silently
// reads are combinational, writes land on the clock edge with no stall

`timescale 1ns/1ps

module trigger_csr_regs import trigger_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  csr_req_t        csr_req,   // address, strobe, data from the core
	input  logic            d_mode,    // core in debug mode
	output xdata_t          csr_rdata, // follows address and state in the same cycle
	output trig_cfg_array_t trig_cfg   // every trigger, to the comparators
);

	// ----------------------------------------
	// state
	// ----------------------------------------
	tsel_t           tselect;
	trig_cfg_array_t cfg_q;

	tidx_t sel_idx;    // low bits of tselect
	logic  sel_valid;  // tselect names a real trigger
	logic  sel_locked; // selected trigger belongs to debug mode and we are not in it
	logic  wr_tselect;
	logic  wr_tdata1;
	logic  wr_tdata2;

	assign sel_idx    = tselect[TIDX_W-1:0];
	assign sel_valid  = (tselect < tsel_t'(NUM_TRIGGERS));
	assign sel_locked = cfg_q[sel_idx].dmode && !d_mode;

	// write decode
	assign wr_tselect = csr_req.we && (csr_req.addr == CSR_TSELECT);
	assign wr_tdata1  = csr_req.we && (csr_req.addr == CSR_TDATA1) && sel_valid && !sel_locked;
	assign wr_tdata2  = csr_req.we && (csr_req.addr == CSR_TDATA2) && sel_valid && !sel_locked;

	// build the mcontrol view of one trigger
	function automatic xdata_t pack_tdata1(input trig_cfg_t c);
		xdata_t d;
		d = '0;                                    // maskmax, hit, timing, match... all zero
		d[XLEN-1:TD1_TYPE_LSB] = TDATA1_TYPE_MCONTROL;
		d[TD1_DMODE_BIT]       = c.dmode;
		d[TD1_ACTION_BIT]      = c.action;         // action 0 or 1 only
		d[TD1_M_BIT]           = c.m;
		d[TD1_U_BIT]           = c.u;              // s bit stays zero, no s-mode
		d[TD1_EXECUTE_BIT]     = c.execute;        // load/store never set
		return d;
	endfunction

	// ----------------------------------------
	// tselect
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tselect <= '0;
		end else if (wr_tselect) begin
			tselect <= csr_req.wdata[TSEL_W-1:0]; // out-of-range values kept, they read back
		end
	end

	// ----------------------------------------
	// per-trigger config
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_TRIGGERS; i++) begin
				cfg_q[i] <= '0; // disabled, no owner, address 0
			end
		end else begin
			for (int i = 0; i < NUM_TRIGGERS; i++) begin
				if (wr_tdata1 && (sel_idx == tidx_t'(i))) begin
					cfg_q[i].action  <= csr_req.wdata[TD1_ACTION_BIT];
					cfg_q[i].m       <= csr_req.wdata[TD1_M_BIT];
					cfg_q[i].u       <= csr_req.wdata[TD1_U_BIT];
					cfg_q[i].execute <= csr_req.wdata[TD1_EXECUTE_BIT];
					// only the debugger may hand a trigger to debug mode
					if (d_mode) begin
						cfg_q[i].dmode <= csr_req.wdata[TD1_DMODE_BIT];
					end
				end
				if (wr_tdata2 && (sel_idx == tidx_t'(i))) begin
					cfg_q[i].tdata2 <= csr_req.wdata; // full address, exact match
				end
			end
		end
	end

	assign trig_cfg = cfg_q;

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	always_comb begin
		csr_rdata = '0; // unknown address reads zero
		case (csr_req.addr)
			CSR_TSELECT: begin
				csr_rdata = xdata_t'(tselect); // zero-extended
			end
			CSR_TDATA1: begin
				if (sel_valid) begin
					csr_rdata = pack_tdata1(cfg_q[sel_idx]);
				end // nonexistent -> type 0, all zero
			end
			CSR_TDATA2: begin
				if (sel_valid) begin
					csr_rdata = cfg_q[sel_idx].tdata2;
				end
			end
			CSR_TINFO: begin
				csr_rdata = sel_valid ? TINFO_MCONTROL : TINFO_NONE;
			end
			default: begin
				csr_rdata = '0;
			end
		endcase
	end

endmodule

// ==== hw/trigger_match.sv ====
// pc comparators for all triggers, early timing only; outputs are pure combinational levels
// several triggers may hit at once, requests are simply ORed

`timescale 1ns/1ps

module trigger_match import trigger_pkg::*; (
	input  trig_cfg_array_t trig_cfg,     // setup from the register block
	input  core_state_t     core_state,   // pc and mode of the current cycle
	output logic            break_any,    // some trigger wants a break
	output logic            break_d_mode  // ...and it goes to debug mode
);

	// ----------------------------------------
	// per-trigger evaluation
	// ----------------------------------------
	logic [NUM_TRIGGERS-1:0] hit;       // address and mode qualify
	logic [NUM_TRIGGERS-1:0] want_d;    // request for debug-mode entry
	logic [NUM_TRIGGERS-1:0] want_m;    // request for m-mode breakpoint exception

	for (genvar i = 0; i < NUM_TRIGGERS; i++) begin : g_trig
		logic addr_eq;
		logic priv_ok;

		// exact match only, no mask or range
		assign addr_eq = (trig_cfg[i].tdata2 == core_state.pc);

		// each trigger carries its own privilege enables
		assign priv_ok = core_state.m_mode ? trig_cfg[i].m : trig_cfg[i].u;

		// triggers never fire while halted
		assign hit[i] = trig_cfg[i].execute
			&& addr_eq
			&& priv_ok
			&& !core_state.d_mode;

		// action 1 only means something for a debug-owned trigger
		assign want_d[i] = hit[i] && trig_cfg[i].action && trig_cfg[i].dmode;

		// action 0 is an m-mode break, subject to the global enable
		assign want_m[i] = hit[i] && !trig_cfg[i].action && core_state.trig_m_en;

		// action 1 with dmode 0 falls through both terms and requests nothing
	end

	// ----------------------------------------
	// reduce
	// ----------------------------------------
	assign break_d_mode = |want_d;
	assign break_any    = |want_d || |want_m; // debug wins at the core if both

endmodule

// ==== hw/trigger_pkg.sv ====
// shared types for the breakpoint trigger unit, exact-address execute triggers only
// trigger count is fixed here; tselect is one bit wider so software can probe past the end

package trigger_pkg;

	// ----------------------------------------
	// sizes
	// ----------------------------------------
	localparam int NUM_TRIGGERS = 4;                    // implemented breakpoint triggers
	localparam int TIDX_W       = $clog2(NUM_TRIGGERS); // index of an existing trigger
	localparam int TSEL_W       = TIDX_W + 1;           // tselect, one spare bit
	localparam int XLEN         = 32;                   // rv32

	// widths with a meaning
	typedef logic [11:0]       csr_addr_t;
	typedef logic [XLEN-1:0]   xdata_t;
	typedef logic [XLEN-1:0]   pc_t;
	typedef logic [TSEL_W-1:0] tsel_t;
	typedef logic [TIDX_W-1:0] tidx_t;

	// ----------------------------------------
	// csr map
	// ----------------------------------------
	localparam csr_addr_t CSR_TSELECT = 12'h7a0;
	localparam csr_addr_t CSR_TDATA1  = 12'h7a1;
	localparam csr_addr_t CSR_TDATA2  = 12'h7a2;
	localparam csr_addr_t CSR_TINFO   = 12'h7a4;

	localparam logic [3:0] TDATA1_TYPE_MCONTROL = 4'd2; // address/data match
	localparam xdata_t     TINFO_MCONTROL       = 32'h0000_0004; // only type 2 supported
	localparam xdata_t     TINFO_NONE           = 32'h0000_0001; // no trigger here

	// tdata1 (mcontrol) field positions
	localparam int TD1_TYPE_LSB    = 28; // type sits in 31:28
	localparam int TD1_DMODE_BIT   = 27;
	localparam int TD1_ACTION_BIT  = 12; // low bit of action, upper bits read zero
	localparam int TD1_M_BIT       = 6;
	localparam int TD1_U_BIT       = 3;
	localparam int TD1_EXECUTE_BIT = 2;

	// ----------------------------------------
	// bundles
	// ----------------------------------------

	// one csr access from the core pipeline
	typedef struct packed {
		csr_addr_t addr;
		logic      we;    // write strobe, one write per edge
		xdata_t    wdata;
	} csr_req_t;

	// what the core tells us about itself this cycle
	typedef struct packed {
		pc_t  pc;
		logic m_mode;     // 1 = machine, 0 = user
		logic d_mode;     // core halted in debug mode
		logic trig_m_en;  // global enable for breaks into m-mode
	} core_state_t;

	// stored setup of one trigger
	typedef struct packed {
		logic   dmode;    // owned by debug mode
		logic   action;   // 0 = m-mode break, 1 = enter debug mode
		logic   m;
		logic   u;
		logic   execute;
		xdata_t tdata2;   // match address
	} trig_cfg_t;

	typedef trig_cfg_t [NUM_TRIGGERS-1:0] trig_cfg_array_t;

endpackage

// ==== hw/trigger_unit.sv ====
// breakpoint trigger unit top, only wiring; csr access is a bare strobe, no handshake
// breaks follow pc with zero latency and config writes with one cycle

`timescale 1ns/1ps

module trigger_unit import trigger_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  csr_req_t    csr_req,      // csr port from the pipeline
	input  core_state_t core_state,   // pc, privilege, debug state, m-mode enable
	output xdata_t      csr_rdata,    // combinational read data
	output logic        break_any,    // break request level
	output logic        break_d_mode  // break target is debug mode
);

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	trig_cfg_array_t trig_cfg; // regs -> comparators

	// ----------------------------------------
	// csr registers
	// ----------------------------------------
	trigger_csr_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.csr_req   (csr_req),
		.d_mode    (core_state.d_mode), // unlocks debug-owned triggers
		.csr_rdata (csr_rdata),
		.trig_cfg  (trig_cfg)
	);

	// ----------------------------------------
	// address match
	// ----------------------------------------
	trigger_match u_match (
		.trig_cfg     (trig_cfg),
		.core_state   (core_state),
		.break_any    (break_any),
		.break_d_mode (break_d_mode)
	);

endmodule

// ==== test/trigger_unit_sva.sv ====
// output relations of the trigger unit, bound to the top level
// sampled on the rising edge, inputs settle before it

`timescale 1ns/1ps

module trigger_unit_sva import trigger_pkg::*; (
	input logic        clk,
	input logic        rst_n,
	input core_state_t core_state,
	input logic        break_any,
	input logic        break_d_mode
);

	// ----------------------------------------
	// break relations
	// ----------------------------------------
	a_dmode_needs_any: assert property (@(posedge clk) disable iff (!rst_n)
		break_d_mode |-> break_any)
		else $error("break_d_mode high without break_any");

	// halted core never sees a trigger
	a_quiet_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
		core_state.d_mode |-> !break_any)
		else $error("break raised while in debug mode");

	a_quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> (!break_any && !break_d_mode))
		else $error("break raised during reset");

endmodule

bind trigger_unit trigger_unit_sva u_sva (
	.clk          (clk),
	.rst_n        (rst_n),
	.core_state   (core_state),
	.break_any    (break_any),
	.break_d_mode (break_d_mode)
);

// ==== test/trigger_unit_tb.sv ====
// random csr and pc stimulus against a tb-side model of the trigger rules, fixed seed
// inputs change on the rising edge, results are compared on the falling edge

`timescale 1ns/1ps

module trigger_unit_tb import trigger_pkg::*; ();

	// ----------------------------------------
	// run length
	// ----------------------------------------
	localparam int SEED      = 32'hbfe0_48be;
	localparam int N_CFG     = 60;  // debug-mode config rounds, 5 ops each
	localparam int N_OOR     = 20;  // tselect past the end, 5 ops each
	localparam int N_USER    = 60;  // writes outside debug mode, 4 ops each
	localparam int N_MATCH   = 600; // mixed pc and csr traffic
	localparam int N_NEXT    = 40;  // write then hit next cycle, 4 ops each
	localparam int TOTAL_OPS = 17 + 12 + 5 * N_CFG + 24 + 5 * N_OOR + 4 * N_USER
		+ N_MATCH + 4 * N_NEXT + 1;

	typedef struct packed {
		logic any;
		logic d_mode;
	} brk_t;

	logic        clk;
	logic        rst_n;
	csr_req_t    csr_req;
	core_state_t core_state;
	xdata_t      csr_rdata;
	logic        break_any;
	logic        break_d_mode;
	int          errors;

	// model of the stored state
	tsel_t  m_tsel;
	logic   m_dmode  [NUM_TRIGGERS];
	logic   m_action [NUM_TRIGGERS];
	logic   m_m      [NUM_TRIGGERS];
	logic   m_u      [NUM_TRIGGERS];
	logic   m_exec   [NUM_TRIGGERS];
	xdata_t m_tdata2 [NUM_TRIGGERS];

	trigger_unit u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.csr_req      (csr_req),
		.core_state   (core_state),
		.csr_rdata    (csr_rdata),
		.break_any    (break_any),
		.break_d_mode (break_d_mode)
	);

	always #20 clk = ~clk; // 40 ns period

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic xdata_t exp_tdata1(input int i);
		// type 2 on top, single bits for dmode, action, m, u, execute
		return {4'h2, m_dmode[i], 14'b0, m_action[i], 5'b0, m_m[i], 2'b0, m_u[i], m_exec[i],
			2'b0};
	endfunction

	function automatic xdata_t exp_read(input csr_addr_t a);
		logic valid;
		valid = (m_tsel < NUM_TRIGGERS);
		case (a)
			CSR_TSELECT: return {{(32 - TSEL_W){1'b0}}, m_tsel};
			CSR_TDATA1:  return valid ? exp_tdata1(m_tsel) : 32'h0;
			CSR_TDATA2:  return valid ? m_tdata2[m_tsel] : 32'h0;
			CSR_TINFO:   return valid ? 32'h4 : 32'h1;
			default:     return 32'h0;
		endcase
	endfunction

	function automatic brk_t exp_break(input core_state_t cs);
		brk_t b;
		logic hit;
		b = '0;
		for (int i = 0; i < NUM_TRIGGERS; i++) begin
			hit = m_exec[i] && (m_tdata2[i] == cs.pc) && !cs.d_mode
				&& (cs.m_mode ? m_m[i] : m_u[i]);
			if (hit && m_action[i] && m_dmode[i]) begin
				b.any    = 1'b1;
				b.d_mode = 1'b1;
			end
			if (hit && !m_action[i] && cs.trig_m_en) begin
				b.any = 1'b1; // m-mode break
			end
		end
		return b;
	endfunction

	task automatic model_write(input csr_addr_t a, input xdata_t d, input logic dm);
		int i;
		i = m_tsel;
		if (a == CSR_TSELECT) begin
			m_tsel = d[TSEL_W-1:0];
		end else if ((a == CSR_TDATA1 || a == CSR_TDATA2) && m_tsel < NUM_TRIGGERS) begin
			if (dm || !m_dmode[i]) begin // debug-owned trigger locked outside debug mode
				if (a == CSR_TDATA2) begin
					m_tdata2[i] = d;
				end else begin
					m_action[i] = d[12];
					m_m[i]      = d[6];
					m_u[i]      = d[3];
					m_exec[i]   = d[2];
					if (dm) begin
						m_dmode[i] = d[27];
					end
				end
			end
		end
	endtask

	// follow the dut on every write edge, inputs still hold the previous cycle
	always @(posedge clk) begin
		if (rst_n && csr_req.we) begin
			model_write(csr_req.addr, csr_req.wdata, core_state.d_mode);
		end
	end

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_rdata(input string name, input xdata_t exp, input xdata_t act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_break(input brk_t exp, input brk_t act);
		if (exp !== act) begin
			errors++;
			$display("[ERROR] %0t ns break_any/break_d_mode expected %b got %b", $time, exp, act);
		end
	endtask

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	function automatic core_state_t rand_state(input pc_t pc, input logic dm);
		core_state_t cs;
		cs.pc        = pc;
		cs.m_mode    = 1'($urandom);
		cs.d_mode    = dm;
		cs.trig_m_en = 1'($urandom);
		return cs;
	endfunction

	function automatic pc_t pick_pc();
		if ($urandom % 2) begin
			return $urandom;
		end
		return m_tdata2[$urandom % NUM_TRIGGERS]; // aim at a stored address
	endfunction

	// small address pool so several triggers often share one address
	function automatic xdata_t rand_tdata2();
		return ($urandom % 2) ? $urandom : 32'h8000_0000 + ($urandom % 4) * 4;
	endfunction

	function automatic csr_addr_t pick_addr();
		case ($urandom % 5)
			0:       return CSR_TSELECT;
			1:       return CSR_TDATA1;
			2:       return CSR_TDATA2;
			3:       return CSR_TINFO;
			default: return 12'($urandom); // mostly unmapped
		endcase
	endfunction

	// one cycle: drive, then compare read data and breaks mid-cycle
	task automatic step(input csr_addr_t a, input logic we, input xdata_t d,
		input core_state_t cs);
		@(posedge clk);
		csr_req.addr  <= a;
		csr_req.we    <= we;
		csr_req.wdata <= d;
		core_state    <= cs;
		@(negedge clk);
		check_rdata("csr_rdata", exp_read(a), csr_rdata);
		check_break(exp_break(cs), brk_t'({break_any, break_d_mode}));
	endtask

	task automatic sweep_readback();
		for (int t = 0; t < NUM_TRIGGERS; t++) begin
			step(CSR_TSELECT, 1'b1, t, rand_state(pick_pc(), 1'b1));
			step(CSR_TDATA1, 1'b0, '0, rand_state(pick_pc(), 1'b1));
			step(CSR_TDATA2, 1'b0, '0, rand_state(pick_pc(), 1'b1));
		end
	endtask

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial begin
		#(TOTAL_OPS * 40 * 2);
		$display("timeout, the test sequence did not finish in time");
		$display("ERRORS FOUND");
		$finish;
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		int t;
		xdata_t a;
		errors     = 0;
		void'($urandom(SEED));
		clk        = 1'b0;
		rst_n      = 1'b0;
		csr_req    = '0;
		core_state = '0;
		m_tsel     = '0;
		for (int i = 0; i < NUM_TRIGGERS; i++) begin
			m_dmode[i]  = 1'b0;
			m_action[i] = 1'b0;
			m_m[i]      = 1'b0;
			m_u[i]      = 1'b0;
			m_exec[i]   = 1'b0;
			m_tdata2[i] = '0;
		end

		repeat (16) begin
			@(negedge clk);
			check_break('0, brk_t'({break_any, break_d_mode})); // quiet in reset
		end
		@(posedge clk);
		rst_n <= 1'b1;

		// reset values
		step(CSR_TSELECT, 1'b0, '0, rand_state($urandom, 1'b0));
		step(CSR_TDATA1, 1'b0, '0, rand_state($urandom, 1'b0));
		step(CSR_TDATA2, 1'b0, '0, rand_state($urandom, 1'b0));
		step(CSR_TINFO, 1'b0, '0, rand_state($urandom, 1'b0));
		repeat (8) step(pick_addr(), 1'b0, '0, rand_state($urandom, 1'($urandom)));

		// config in debug mode with readback
		repeat (N_CFG) begin
			t = $urandom % NUM_TRIGGERS;
			step(CSR_TSELECT, 1'b1, t, rand_state(pick_pc(), 1'b1));
			step(CSR_TDATA1, 1'b1, $urandom, rand_state(pick_pc(), 1'b1));
			step(CSR_TDATA2, 1'b1, rand_tdata2(), rand_state(pick_pc(), 1'b1));
			step(CSR_TDATA1, 1'b0, '0, rand_state(pick_pc(), 1'b1));
			step(CSR_TDATA2, 1'b0, '0, rand_state(pick_pc(), 1'b1));
		end

		// tselect 4..7, nothing behind it
		repeat (N_OOR) begin
			step(CSR_TSELECT, 1'b1, 4 + $urandom % 4, rand_state(pick_pc(), 1'($urandom)));
			step(($urandom % 2) ? CSR_TDATA1 : CSR_TDATA2, 1'b1, $urandom,
				rand_state(pick_pc(), 1'($urandom)));
			step(CSR_TINFO, 1'b0, '0, rand_state(pick_pc(), 1'b0));
			step(CSR_TDATA1, 1'b0, '0, rand_state(pick_pc(), 1'b0));
			step(CSR_TDATA2, 1'b0, '0, rand_state(pick_pc(), 1'b0));
		end
		sweep_readback();

		// outside debug mode, bit 27 always set in the data
		repeat (N_USER) begin
			t = $urandom % NUM_TRIGGERS;
			step(CSR_TSELECT, 1'b1, t, rand_state(pick_pc(), 1'b0));
			step(CSR_TDATA1, 1'b1, $urandom | 32'h0800_0000, rand_state(pick_pc(), 1'b0));
			step(CSR_TDATA2, 1'b1, rand_tdata2(), rand_state(pick_pc(), 1'b0));
			step(CSR_TDATA1, 1'b0, '0, rand_state(pick_pc(), 1'b0));
		end
		sweep_readback();

		// mixed traffic, pc often on a stored address
		repeat (N_MATCH) begin
			case ($urandom % 6)
				0: step(CSR_TSELECT, 1'b1, $urandom % 8, rand_state(pick_pc(), 1'($urandom)));
				1: step(CSR_TDATA1, 1'b1, $urandom, rand_state(pick_pc(), ($urandom % 3) == 0));
				2: step(CSR_TDATA2, 1'b1, rand_tdata2(), rand_state(pick_pc(), 1'($urandom)));
				default: step(pick_addr(), 1'b0, '0, rand_state(pick_pc(), ($urandom % 4) == 0));
			endcase
		end

		// new tdata2 must already hit in the next cycle
		repeat (N_NEXT) begin
			t = $urandom % NUM_TRIGGERS;
			a = $urandom;
			step(CSR_TSELECT, 1'b1, t, rand_state(pick_pc(), 1'b1));
			step(CSR_TDATA1, 1'b1, 32'h0000_004c | (($urandom % 2) << 12) | (($urandom % 2) << 27),
				rand_state(pick_pc(), 1'b1)); // m, u, execute set
			step(CSR_TDATA2, 1'b1, a, rand_state(pick_pc(), 1'b1));
			step(CSR_TSELECT, 1'b0, '0, '{pc: a, m_mode: 1'($urandom), d_mode: 1'b0,
				trig_m_en: 1'b1});
		end
		step(CSR_TSELECT, 1'b0, '0, rand_state(pick_pc(), 1'b1)); // idle

		$display("run complete, %0d errors", errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
hw/trigger_pkg.sv
hw/trigger_csr_regs.sv
hw/trigger_match.sv
hw/trigger_unit.sv
test/trigger_unit_sva.sv
test/trigger_unit_tb.sv
